/* logic/lq_geom_pkg.sv */
package lq_geom_pkg;

    localparam int lq_depth    = 24;
    localparam int alloc_width = 4;
    localparam int lq_ptr_w    = $clog2(lq_depth);

    typedef logic [lq_ptr_w-1:0] lq_ptr_t;   // entry index, wraps 23 -> 0
    typedef logic [lq_depth-1:0] lq_mask_t;  // one bit per entry

    // a + b modulo the queue depth, both operands already below lq_depth
    function automatic lq_ptr_t ptr_add(lq_ptr_t a, lq_ptr_t b);
        logic [lq_ptr_w:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        if (sum >= (lq_ptr_w + 1)'(lq_depth)) begin
            sum = sum - (lq_ptr_w + 1)'(lq_depth);
        end
        return sum[lq_ptr_w-1:0];
    endfunction

endpackage

/* logic/lq_data_pkg.sv */
package lq_data_pkg;

    localparam int lq_tag_w  = 7;
    localparam int preg_w    = 6;
    localparam int ld_addr_w = 16;
    localparam int ld_data_w = 16;

    typedef logic [lq_tag_w-1:0]  lq_tag_t;   // load tag from rename
    typedef logic [preg_w-1:0]    preg_t;     // destination physical register
    typedef logic [ld_addr_w-1:0] ld_addr_t;
    typedef logic [ld_data_w-1:0] ld_data_t;

    typedef enum logic [2:0] {
        idle,
        wait_grant,  // requesting the memory port
        issued,      // granted, no answer yet
        mem_ready,   // cache data held, store queue pending
        fwd_ready,   // store queue answer held, cache pending
        both_ready,  // both answers held, result goes out
        writeback    // entry marked done at the end of this cycle
    } issue_state_t;

endpackage

/* logic/lq_alloc.sv */
`timescale 1ns/1ps

module lq_alloc
    import lq_geom_pkg::*;
    import lq_data_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic [alloc_width-1:0]        alloc_vld,
    input  lq_tag_t [alloc_width-1:0]     alloc_tag,
    input  logic                          flush,
    input  lq_ptr_t                       flush_ptr,
    input  logic                          tail_busy,
    output lq_mask_t                      insert_mask,
    output lq_tag_t [lq_depth-1:0]        insert_tag,
    output lq_ptr_t                       tail,
    output logic                          stall
);

    logic [2:0] alloc_cnt;
    logic       alloc_ok;

    assign stall    = tail_busy;      // queue full when the tail slot is still taken
    assign alloc_ok = !stall && !flush;

    // only a contiguous run from slot 0 counts
    always_comb begin
        case (alloc_vld)
            4'b0001: alloc_cnt = 3'd1;
            4'b0011: alloc_cnt = 3'd2;
            4'b0111: alloc_cnt = 3'd3;
            4'b1111: alloc_cnt = 3'd4;
            default: alloc_cnt = 3'd0;
        endcase
        if (!alloc_ok) begin
            alloc_cnt = 3'd0;
        end
    end

    // slot s lands at tail + s
    always_comb begin
        insert_mask = '0;
        insert_tag  = '0;
        for (int s = 0; s < alloc_width; s++) begin
            if (s < int'(alloc_cnt)) begin
                insert_mask[ptr_add(tail, lq_ptr_t'(s))] = 1'b1;
                insert_tag[ptr_add(tail, lq_ptr_t'(s))]  = alloc_tag[s];
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            tail <= '0;
        end else if (flush) begin
            tail <= flush_ptr;            // drop wrong-path loads
        end else begin
            tail <= ptr_add(tail, lq_ptr_t'(alloc_cnt));
        end
    end

endmodule

/* logic/lq_entries.sv */
`timescale 1ns/1ps

module lq_entries
    import lq_geom_pkg::*;
    import lq_data_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  lq_mask_t               insert_mask,
    input  lq_tag_t [lq_depth-1:0] insert_tag,
    input  logic                   agu_vld,
    input  lq_tag_t                agu_tag,
    input  ld_addr_t               agu_addr,
    input  preg_t                  agu_preg,
    input  lq_ptr_t                cmmt_ptr,
    input  logic                   flush,
    input  lq_ptr_t                flush_ptr,
    input  lq_ptr_t                tail,
    input  lq_ptr_t                current,
    input  logic                   finish,
    output lq_mask_t               ready_mask,
    output logic                   tail_busy,
    output lq_ptr_t                head,
    output ld_addr_t               cur_addr,
    output preg_t                  cur_preg,
    output lq_tag_t                cur_tag
);

    lq_mask_t occ;        // entry holds a live load
    lq_mask_t addr_vld;   // address and register filled in
    lq_mask_t done;
    lq_tag_t  tag_q  [lq_depth];
    ld_addr_t addr_q [lq_depth];
    preg_t    preg_q [lq_depth];

    lq_mask_t commit_mask;
    lq_mask_t flush_mask;
    lq_mask_t fill_hit;
    lq_mask_t cur_sel;

    // wrapped range from lo up to hi minus one and empty when lo equals hi
    function automatic lq_mask_t range_mask(lq_ptr_t lo, lq_ptr_t hi);
        lq_mask_t m;
        for (int i = 0; i < lq_depth; i++) begin
            if (lo <= hi) begin
                m[i] = (lq_ptr_t'(i) >= lo) && (lq_ptr_t'(i) < hi);
            end else begin
                m[i] = (lq_ptr_t'(i) >= lo) || (lq_ptr_t'(i) < hi);
            end
        end
        return m;
    endfunction

    assign commit_mask = range_mask(head, cmmt_ptr);
    assign flush_mask  = range_mask(flush_ptr, tail);

    always_comb begin
        for (int i = 0; i < lq_depth; i++) begin
            fill_hit[i] = agu_vld && occ[i] && (tag_q[i] == agu_tag);
            cur_sel[i]  = (current == lq_ptr_t'(i));
        end
    end

    assign ready_mask = occ & addr_vld & ~done;
    assign tail_busy  = occ[tail];
    assign cur_addr   = addr_q[current];
    assign cur_preg   = preg_q[current];
    assign cur_tag    = tag_q[current];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            head <= '0;
        end else begin
            head <= cmmt_ptr;
        end
    end

    // flush wins over commit and commit over insert in each entry
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            occ      <= '0;
            addr_vld <= '0;
            done     <= '0;
        end else begin
            for (int i = 0; i < lq_depth; i++) begin
                if ((flush && flush_mask[i]) || commit_mask[i]) begin
                    occ[i]      <= 1'b0;
                    addr_vld[i] <= 1'b0;
                    done[i]     <= 1'b0;
                end else if (insert_mask[i]) begin
                    occ[i]      <= 1'b1;
                    addr_vld[i] <= 1'b0;
                    done[i]     <= 1'b0;
                end else begin
                    if (fill_hit[i]) addr_vld[i] <= 1'b1;
                    if (finish && cur_sel[i]) done[i] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < lq_depth; i++) begin
            if (insert_mask[i]) tag_q[i] <= insert_tag[i];
            if (fill_hit[i]) begin
                addr_q[i] <= agu_addr;
                preg_q[i] <= agu_preg;
            end
        end
    end

endmodule

/* logic/lq_select.sv */
`timescale 1ns/1ps

module lq_select
    import lq_geom_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  lq_mask_t ready_mask,
    input  lq_ptr_t  head,
    input  logic     busy,
    output lq_ptr_t  current,
    output logic     ld_rdy
);

    lq_mask_t rot_mask;   // ready bits with the head at bit 0
    lq_ptr_t  pick_ofs;   // distance of the oldest ready load from head
    lq_ptr_t  pick;

    always_comb begin
        for (int k = 0; k < lq_depth; k++) begin
            rot_mask[k] = ready_mask[ptr_add(head, lq_ptr_t'(k))];
        end
    end

    // lowest set bit wins, so scan from the top down
    always_comb begin
        pick_ofs = '0;
        for (int k = lq_depth - 1; k >= 0; k--) begin
            if (rot_mask[k]) begin
                pick_ofs = lq_ptr_t'(k);
            end
        end
    end

    assign pick   = ptr_add(head, pick_ofs);
    assign ld_rdy = |ready_mask;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            current <= '0;
        end else if (!busy) begin
            current <= pick;     // frozen while a load is in flight
        end
    end

endmodule

/* logic/lq_issue.sv */
`timescale 1ns/1ps

module lq_issue
    import lq_data_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     ld_rdy,
    input  logic     ld_grnt,
    input  logic     mem_done,
    input  ld_data_t mem_data,
    input  logic     fwd_done,
    input  logic     fwd_hit,
    input  ld_data_t fwd_data,
    output logic     ld_req,
    output logic     busy,
    output logic     finish,
    output logic     wb_vld,
    output ld_data_t wb_data
);

    issue_state_t state;
    issue_state_t state_nxt;

    logic     fwd_hit_q;
    ld_data_t mem_data_q;
    ld_data_t fwd_data_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            idle: begin
                if (ld_rdy) state_nxt = wait_grant;
            end
            wait_grant: begin
                if (ld_grnt) state_nxt = issued;
            end
            issued: begin
                if (mem_done && fwd_done) begin
                    state_nxt = both_ready;
                end else if (mem_done) begin
                    state_nxt = mem_ready;
                end else if (fwd_done) begin
                    state_nxt = fwd_ready;
                end
            end
            mem_ready: begin
                if (fwd_done) state_nxt = both_ready;
            end
            fwd_ready: begin
                if (mem_done) state_nxt = both_ready;
            end
            both_ready: state_nxt = writeback;
            writeback:  state_nxt = idle;
            default:    state_nxt = idle;
        endcase
    end

    // each answer is held from its own strobe
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            fwd_hit_q <= 1'b0;
        end else if (fwd_done) begin
            fwd_hit_q <= fwd_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_done) mem_data_q <= mem_data;
        if (fwd_done) fwd_data_q <= fwd_data;
    end

    assign ld_req = (state == wait_grant);

    // the grant term keeps the picked entry stable across the grant edge
    assign busy = (state inside {issued, mem_ready, fwd_ready, both_ready, writeback})
                  || ((state == wait_grant) && ld_grnt);

    assign wb_vld  = (state == both_ready);           // cycle after the later answer
    assign wb_data = fwd_hit_q ? fwd_data_q : mem_data_q;
    assign finish  = (state == writeback);

endmodule

/* logic/load_queue.sv */
`timescale 1ns/1ps

module load_queue
    import lq_geom_pkg::*;
    import lq_data_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic [alloc_width-1:0]    alloc_vld,
    input  lq_tag_t [alloc_width-1:0] alloc_tag,
    input  logic                      agu_vld,
    input  lq_tag_t                   agu_tag,
    input  ld_addr_t                  agu_addr,
    input  preg_t                     agu_preg,
    input  lq_ptr_t                   cmmt_ptr,
    input  logic                      flush,
    input  lq_ptr_t                   flush_ptr,
    input  logic                      ld_grnt,
    input  logic                      mem_done,
    input  ld_data_t                  mem_data,
    input  logic                      fwd_done,
    input  logic                      fwd_hit,
    input  ld_data_t                  fwd_data,
    output logic                      stall,
    output logic                      ld_req,
    output ld_addr_t                  ld_addr,
    output lq_tag_t                   ld_tag,
    output logic                      wb_vld,
    output preg_t                     wb_preg,
    output ld_data_t                  wb_data
);

    lq_mask_t               insert_mask;
    lq_tag_t [lq_depth-1:0] insert_tag;
    lq_ptr_t                tail;
    lq_ptr_t                head;
    lq_ptr_t                current;
    logic                   tail_busy;
    lq_mask_t               ready_mask;
    logic                   ld_rdy;
    logic                   busy;
    logic                   finish;

    lq_alloc u_lq_alloc (
        .clk         (clk),
        .rst         (rst),
        .alloc_vld   (alloc_vld),
        .alloc_tag   (alloc_tag),
        .flush       (flush),
        .flush_ptr   (flush_ptr),
        .tail_busy   (tail_busy),
        .insert_mask (insert_mask),
        .insert_tag  (insert_tag),
        .tail        (tail),
        .stall       (stall)
    );

    lq_entries u_lq_entries (
        .clk         (clk),
        .rst         (rst),
        .insert_mask (insert_mask),
        .insert_tag  (insert_tag),
        .agu_vld     (agu_vld),
        .agu_tag     (agu_tag),
        .agu_addr    (agu_addr),
        .agu_preg    (agu_preg),
        .cmmt_ptr    (cmmt_ptr),
        .flush       (flush),
        .flush_ptr   (flush_ptr),
        .tail        (tail),
        .current     (current),
        .finish      (finish),
        .ready_mask  (ready_mask),
        .tail_busy   (tail_busy),
        .head        (head),
        .cur_addr    (ld_addr),    // current entry goes straight to the port
        .cur_preg    (wb_preg),
        .cur_tag     (ld_tag)
    );

    lq_select u_lq_select (
        .clk        (clk),
        .rst        (rst),
        .ready_mask (ready_mask),
        .head       (head),
        .busy       (busy),
        .current    (current),
        .ld_rdy     (ld_rdy)
    );

    lq_issue u_lq_issue (
        .clk      (clk),
        .rst      (rst),
        .ld_rdy   (ld_rdy),
        .ld_grnt  (ld_grnt),
        .mem_done (mem_done),
        .mem_data (mem_data),
        .fwd_done (fwd_done),
        .fwd_hit  (fwd_hit),
        .fwd_data (fwd_data),
        .ld_req   (ld_req),
        .busy     (busy),
        .finish   (finish),
        .wb_vld   (wb_vld),
        .wb_data  (wb_data)
    );

endmodule

/* dv/load_queue_tb.sv */
`timescale 1ns/1ps

module load_queue_tb
    import lq_geom_pkg::*;
    import lq_data_pkg::*;
();

    localparam int wait_limit = 200;   // cycles per wait loop
    localparam int max_cases  = 32;

    logic                      clk = 1'b0;
    logic                      rst;
    logic [alloc_width-1:0]    alloc_vld;
    lq_tag_t [alloc_width-1:0] alloc_tag;
    logic                      agu_vld;
    lq_tag_t                   agu_tag;
    ld_addr_t                  agu_addr;
    preg_t                     agu_preg;
    lq_ptr_t                   cmmt_ptr;
    logic                      flush;
    lq_ptr_t                   flush_ptr;
    logic                      ld_grnt;
    logic                      mem_done;
    ld_data_t                  mem_data;
    logic                      fwd_done;
    logic                      fwd_hit;
    ld_data_t                  fwd_data;
    logic                      stall;
    logic                      ld_req;
    ld_addr_t                  ld_addr;
    lq_tag_t                   ld_tag;
    logic                      wb_vld;
    preg_t                     wb_preg;
    ld_data_t                  wb_data;

    // tag, preg, addr, mem data, fwd data, hit nibble, order nibble
    logic [71:0] case_mem [0:max_cases-1];
    int          n_cases;
    lq_ptr_t     tail_model;   // where the next load lands
    int          err_count;
    int          err_base;
    int          test_count;
    int          pass_count;
    bit          aborted;

    always #20 clk = ~clk;

    load_queue u_load_queue (
        .clk(clk), .rst(rst), .alloc_vld(alloc_vld), .alloc_tag(alloc_tag),
        .agu_vld(agu_vld), .agu_tag(agu_tag), .agu_addr(agu_addr), .agu_preg(agu_preg),
        .cmmt_ptr(cmmt_ptr), .flush(flush), .flush_ptr(flush_ptr), .ld_grnt(ld_grnt),
        .mem_done(mem_done), .mem_data(mem_data), .fwd_done(fwd_done), .fwd_hit(fwd_hit),
        .fwd_data(fwd_data), .stall(stall), .ld_req(ld_req), .ld_addr(ld_addr),
        .ld_tag(ld_tag), .wb_vld(wb_vld), .wb_preg(wb_preg), .wb_data(wb_data)
    );

    function automatic lq_tag_t case_tag(int i);
        return lq_tag_t'(case_mem[i][71:64]);
    endfunction

    function automatic preg_t case_preg(int i);
        return preg_t'(case_mem[i][63:56]);
    endfunction

    function automatic ld_addr_t case_addr(int i);
        return case_mem[i][55:40];
    endfunction

    // store queue data wins on a forward hit
    function automatic ld_data_t expected_wb(int i);
        return case_mem[i][4] ? case_mem[i][23:8] : case_mem[i][39:24];
    endfunction

    function automatic lq_ptr_t next_ptr(lq_ptr_t p, int n);
        return lq_ptr_t'((int'(p) + n) % lq_depth);
    endfunction

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_preg(input string name, input preg_t got, input preg_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_data(input string name, input ld_data_t got, input ld_data_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_addr(input string name, input ld_addr_t got, input ld_addr_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_tag(input string name, input lq_tag_t got, input lq_tag_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t: %s did not happen within %0d cycles", $time, what, wait_limit);
        err_count++;
        aborted = 1'b1;
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (err_count == err_base) begin
            pass_count++;
            $display("pass  %s", name);
        end else begin
            $display("fail  %s with %0d errors", name, err_count - err_base);
        end
    endtask

    task automatic allocate(input int cnt, input lq_tag_t t0, t1, t2, t3);
        @(posedge clk);
        alloc_vld <= 4'((1 << cnt) - 1);
        alloc_tag <= {t3, t2, t1, t0};
        @(posedge clk);
        alloc_vld <= '0;
        tail_model = next_ptr(tail_model, cnt);
    endtask

    task automatic fill_case(input int i);
        @(posedge clk);
        agu_vld  <= 1'b1;
        agu_tag  <= case_tag(i);
        agu_addr <= case_addr(i);
        agu_preg <= case_preg(i);
        @(posedge clk);
        agu_vld <= 1'b0;
    endtask

    task automatic expect_request(input int i);
        int n;
        bit seen;
        seen = 1'b0;
        for (n = 0; n < wait_limit && !seen; n++) begin
            @(negedge clk);
            seen = ld_req;
        end
        if (!seen) begin
            report_timeout("ld_req");
            return;
        end
        check_addr("ld_addr", ld_addr, case_addr(i));
        check_tag("ld_tag", ld_tag, case_tag(i));
    endtask

    // arbiter holds the grant back a few cycles while ld_req must stay up
    task automatic grant();
        int d;
        d = $urandom % 4;
        repeat (d) begin
            @(posedge clk);
            @(negedge clk);
            check_flag("ld_req", ld_req, 1'b1);
        end
        @(posedge clk);
        ld_grnt <= 1'b1;
        @(posedge clk);
        ld_grnt <= 1'b0;
    endtask

    task automatic pulse_answers(input int i, input bit mem, input bit fwd);
        @(posedge clk);
        if (mem) begin
            mem_done <= 1'b1;
            mem_data <= case_mem[i][39:24];
        end
        if (fwd) begin
            fwd_done <= 1'b1;
            fwd_hit  <= case_mem[i][4];
            fwd_data <= case_mem[i][23:8];
        end
        @(posedge clk);
        mem_done <= 1'b0;
        fwd_done <= 1'b0;
    endtask

    // cache and store queue answer in the order of the case line
    task automatic respond(input int i);
        int gap;
        gap = $urandom % 3;
        case (case_mem[i][3:0])
            4'd0: begin
                pulse_answers(i, 1'b1, 1'b0);
                repeat (gap) @(posedge clk);
                pulse_answers(i, 1'b0, 1'b1);
            end
            4'd1: begin
                pulse_answers(i, 1'b0, 1'b1);
                repeat (gap) @(posedge clk);
                pulse_answers(i, 1'b1, 1'b0);
            end
            default: pulse_answers(i, 1'b1, 1'b1);
        endcase
    endtask

    task automatic expect_writeback(input int i);
        int n;
        bit seen;
        seen = 1'b0;
        for (n = 0; n < wait_limit && !seen; n++) begin
            @(negedge clk);
            seen = wb_vld;
        end
        if (!seen) begin
            report_timeout("wb_vld");
            return;
        end
        check_preg("wb_preg", wb_preg, case_preg(i));
        check_data("wb_data", wb_data, expected_wb(i));
        @(negedge clk);
        check_flag("wb_vld", wb_vld, 1'b0);   // one pulse only
    endtask

    task automatic commit_all();
        @(posedge clk);
        cmmt_ptr <= tail_model;
        repeat (2) @(posedge clk);
    endtask

    task automatic single_load(input int i);
        allocate(1, case_tag(i), '0, '0, '0);
        fill_case(i);
        expect_request(i);
        if (aborted) return;
        grant();
        respond(i);
        expect_writeback(i);
        if (aborted) return;
        commit_all();
    endtask

    // younger filled first and older filled while the younger is in flight
    task automatic oldest_first();
        allocate(2, case_tag(0), case_tag(1), '0, '0);
        fill_case(1);
        expect_request(1);
        if (aborted) return;
        grant();
        fill_case(0);
        respond(1);
        expect_writeback(1);
        if (aborted) return;
        expect_request(0);
        if (aborted) return;
        grant();
        respond(0);
        expect_writeback(0);
        if (aborted) return;
        commit_all();
    endtask

    task automatic flush_test();
        lq_ptr_t base;
        int n;
        base = tail_model;
        allocate(3, case_tag(2), case_tag(3), case_tag(4), '0);
        @(posedge clk);
        flush     <= 1'b1;
        flush_ptr <= next_ptr(base, 1);
        @(posedge clk);
        flush <= 1'b0;
        tail_model = next_ptr(base, 1);
        fill_case(3);
        fill_case(4);
        for (n = 0; n < wait_limit; n++) begin
            @(negedge clk);
            if (ld_req) begin
                $display("error at %0t: a flushed load requested the memory port", $time);
                err_count++;
                break;
            end
        end
        fill_case(2);
        expect_request(2);
        if (aborted) return;
        grant();
        respond(2);
        expect_writeback(2);
        if (aborted) return;
        commit_all();
    endtask

    task automatic full_queue();
        lq_ptr_t start;
        int k;
        int n;
        bit dropped;
        start = tail_model;
        for (k = 0; k < 6; k++) begin
            @(negedge clk);
            check_flag("stall", stall, 1'b0);
            allocate(4, lq_tag_t'(64 + 4 * k), lq_tag_t'(65 + 4 * k),
                     lq_tag_t'(66 + 4 * k), lq_tag_t'(67 + 4 * k));
        end
        @(negedge clk);
        check_flag("stall", stall, 1'b1);
        @(posedge clk);
        alloc_vld <= 4'hf;   // must be ignored
        alloc_tag <= {7'h7f, 7'h7e, 7'h7d, 7'h7c};
        @(posedge clk);
        alloc_vld <= '0;
        @(negedge clk);
        check_flag("stall", stall, 1'b1);
        @(posedge clk);
        cmmt_ptr <= next_ptr(start, 4);
        dropped = 1'b0;
        for (n = 0; n < wait_limit && !dropped; n++) begin
            @(negedge clk);
            dropped = !stall;
        end
        if (!dropped) begin
            report_timeout("stall release after commit");
            return;
        end
        // tail never moved so four more fill the queue again
        allocate(4, 7'h70, 7'h71, 7'h72, 7'h73);
        @(negedge clk);
        check_flag("stall", stall, 1'b1);
    endtask

    initial begin
        int k;
        void'($urandom(26));
        rst       = 1'b0;
        alloc_vld = '0;
        alloc_tag = '0;
        agu_vld   = 1'b0;
        agu_tag   = '0;
        agu_addr  = '0;
        agu_preg  = '0;
        cmmt_ptr  = '0;
        flush     = 1'b0;
        flush_ptr = '0;
        ld_grnt   = 1'b0;
        mem_done  = 1'b0;
        mem_data  = '0;
        fwd_done  = 1'b0;
        fwd_hit   = 1'b0;
        fwd_data  = '0;
        err_count  = 0;
        test_count = 0;
        pass_count = 0;
        aborted    = 1'b0;
        tail_model = '0;
        for (k = 0; k < max_cases; k++) case_mem[k] = '1;   // all ones marks unused
        $readmemh("dv/lq_cases.txt", case_mem);
        n_cases = 0;
        while (n_cases < max_cases && case_mem[n_cases] != '1) n_cases++;
        if (n_cases < 5) begin
            $display("error: the case file holds %0d cases, at least 5 are needed", n_cases);
            err_count++;
            aborted = 1'b1;
        end

        repeat (10) @(posedge clk);
        rst <= 1'b1;

        err_base = err_count;
        @(negedge clk);
        check_flag("stall", stall, 1'b0);
        check_flag("ld_req", ld_req, 1'b0);
        check_flag("wb_vld", wb_vld, 1'b0);
        end_test("reset");

        for (k = 0; k < n_cases && !aborted; k++) begin
            err_base = err_count;
            single_load(k);
            end_test($sformatf("single load case %0d", k));
        end
        if (!aborted) begin
            err_base = err_count;
            oldest_first();
            end_test("oldest first");
        end
        if (!aborted) begin
            err_base = err_count;
            flush_test();
            end_test("flush");
        end
        if (!aborted) begin
            err_base = err_count;
            full_queue();
            end_test("full queue");
        end

        $display("%0d tests, %0d passed, %0d errors", test_count, pass_count, err_count);
        if (err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* dv/lq_cases.txt */
// tag_preg_addr_memdata_fwddata_fwdhit_order
// order 0 cache first, 1 forward first, 2 together
11_05_1000_a001_f001_0_0
12_06_1004_a002_f002_1_0
13_07_1008_a003_f003_0_1
14_08_100c_a004_f004_1_1
15_09_1010_a005_f005_0_2
16_0a_1014_a006_f006_1_2
27_1b_2f00_beef_cafe_1_0
28_2c_3a50_1234_5678_0_1
39_3d_4ff0_0f0f_f0f0_1_2

/* all.f */
logic/lq_geom_pkg.sv
logic/lq_data_pkg.sv
logic/lq_alloc.sv
logic/lq_entries.sv
logic/lq_select.sv
logic/lq_issue.sv
logic/load_queue.sv
dv/load_queue_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module load_queue_tb \
    --Mdir build -o load_queue_sim
./build/load_queue_sim | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
    exit 1
fi
exit 0
